//--- design/nice_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, custom3 encodings, enums and channel structs of the NICE
// coprocessor. RTL and testbench import it for every typed port
////////////////////////////////////////////////////////////////////////////
package nice_pkg;

  // Data and address width
  localparam int XLEN = 32;

  // Byte step between consecutive words in a row
  localparam logic [XLEN-1:0] WORD_BYTES = 32'd4;

  //////////////////////////////////////////////////////////////////////////
  // custom3 R-type encodings
  //////////////////////////////////////////////////////////////////////////
  localparam logic [6:0] OPC_CUSTOM3   = 7'b1111011;
  localparam logic [2:0] FUNCT3_MEM    = 3'b010;
  localparam logic [2:0] FUNCT3_SUM    = 3'b110;
  localparam logic [6:0] FUNCT7_LBUF   = 7'b0000001;
  localparam logic [6:0] FUNCT7_SBUF   = 7'b0000010;
  localparam logic [6:0] FUNCT7_ROWSUM = 7'b0000110;

  // Decoded operation, OP_NONE also covers unsupported instructions
  typedef enum logic [1:0] {
    OP_NONE   = 2'd0,
    OP_LBUF   = 2'd1,
    OP_SBUF   = 2'd2,
    OP_ROWSUM = 2'd3
  } nice_op_e;

  // Operation FSM
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_LBUF   = 3'd1,
    ST_SBUF   = 3'd2,
    ST_ROWSUM = 3'd3,
    ST_RESP   = 3'd4
  } nice_state_e;

  //////////////////////////////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////////////////////////////

  // Processor request, rs2 is not used by any kept instruction
  typedef struct packed {
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] rs1;
  } nice_req_t;

  // Processor response
  typedef struct packed {
    logic [XLEN-1:0] rdat;
    logic            err;
  } nice_rsp_t;

  // Memory command, always a full word
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            read;
    logic [XLEN-1:0] wdata;
  } icb_cmd_t;

  // Memory response
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;
  } icb_rsp_t;

endpackage

//--- design/nice_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Instruction decode, operation FSM and response channel of the NICE core.
// Starts the load/store unit and reports the result to the processor
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module nice_ctrl #(
  parameter int ROW_LEN = 3
) (
  input  logic                      nice_clk,
  input  logic                      nice_rst_n,
  // Request from the processor
  input  logic                      req_valid,
  output logic                      req_ready,
  input  nice_pkg::nice_req_t       req,
  // Response to the processor
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  output nice_pkg::nice_rsp_t       rsp,
  // Operation start toward the load/store unit and row buffer
  output logic                      start,
  output nice_pkg::nice_op_e        op,
  output logic [nice_pkg::XLEN-1:0] base_addr,
  // Beat reports from the load/store unit
  input  logic                      beat_valid,
  input  logic                      beat_err,
  input  logic                      last_beat,
  input  logic [nice_pkg::XLEN-1:0] row_sum,
  // Core status
  output logic                      active,
  output logic                      mem_holdup
);
  import nice_pkg::*;

  localparam int IDX_W = (ROW_LEN > 1) ? $clog2(ROW_LEN) : 1;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  nice_op_e         dec_op;
  nice_op_e         op_q;
  nice_state_e      state;
  nice_state_e      state_nxt;
  logic             req_hsk;
  logic             err_q;
  logic [IDX_W-1:0] beat_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  // Fields only count while a request is offered
  assign opcode = req_valid ? req.inst[6:0]   : 7'd0;
  assign funct3 = req_valid ? req.inst[14:12] : 3'd0;
  assign funct7 = req_valid ? req.inst[31:25] : 7'd0;

  always_comb
  begin
    dec_op = OP_NONE;
    if (opcode == OPC_CUSTOM3)
    begin
      if (funct3 == FUNCT3_MEM && funct7 == FUNCT7_LBUF)
        dec_op = OP_LBUF;
      else if (funct3 == FUNCT3_MEM && funct7 == FUNCT7_SBUF)
        dec_op = OP_SBUF;
      else if (funct3 == FUNCT3_SUM && funct7 == FUNCT7_ROWSUM)
        dec_op = OP_ROWSUM;
    end
  end

  // Only idle accepts a request, whatever it decodes to
  assign req_ready = (state == ST_IDLE);
  assign req_hsk   = req_valid && req_ready;

  // Unsupported instructions skip memory entirely
  assign start     = req_hsk && (dec_op != OP_NONE);
  assign base_addr = req.rs1;

  // Decoded op while idle so the LSU sees it with start, held op afterwards
  assign op = (state == ST_IDLE) ? dec_op : op_q;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (req_hsk)
        begin
          case (dec_op)
            OP_LBUF:   state_nxt = ST_LBUF;
            OP_SBUF:   state_nxt = ST_SBUF;
            OP_ROWSUM: state_nxt = ST_ROWSUM;
            default:   state_nxt = ST_RESP;
          endcase
        end
      end
      // Memory states end on the final response beat
      ST_LBUF, ST_SBUF, ST_ROWSUM:
      begin
        if (beat_valid && last_beat)
          state_nxt = ST_RESP;
      end
      ST_RESP:
      begin
        if (rsp_ready)
          state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      state    <= ST_IDLE;
      op_q     <= OP_NONE;
      err_q    <= 1'b0;
      beat_cnt <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (req_hsk)
        op_q <= dec_op;
      // Sticky error, preset for an unsupported instruction
      if (req_hsk)
        err_q <= (dec_op == OP_NONE);
      else if (beat_valid && beat_err)
        err_q <= 1'b1;
      // Beat position inside the current row
      if (start)
        beat_cnt <= '0;
      else if (beat_valid)
        beat_cnt <= beat_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response and status
  ////////////////////////////////////////////////////////////////////////////

  // Registered state, so the response holds under back-pressure
  assign rsp_valid = (state == ST_RESP);
  assign rsp.rdat  = (op_q == OP_ROWSUM) ? row_sum : '0;
  assign rsp.err   = (state == ST_RESP) && err_q;

  assign mem_holdup = (state == ST_LBUF) || (state == ST_SBUF) || (state == ST_ROWSUM);
  assign active     = (state != ST_IDLE) || req_valid;

  // Checks
  a_req_only_idle : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (req_valid && req_ready) |-> (state == ST_IDLE))
    else $error("request accepted outside idle");

  a_rsp_hold : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else $error("response changed under back-pressure");

  a_no_idle_beat : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    beat_valid |-> (state != ST_IDLE))
    else $error("memory beat while idle");

  // The LSU must flag exactly the ROW_LEN-th beat as last
  a_last_pos : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    beat_valid |-> (last_beat == (beat_cnt == IDX_W'(ROW_LEN - 1))))
    else $error("last beat out of place");

endmodule

//--- design/nice_lsu.sv
////////////////////////////////////////////////////////////////////////////
// Load/store unit. Issues ROW_LEN word commands from the base address and
// turns each memory response into an indexed beat
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module nice_lsu #(
  parameter  int ROW_LEN = 3,
  localparam int IDX_W   = (ROW_LEN > 1) ? $clog2(ROW_LEN) : 1
) (
  input  logic                      nice_clk,
  input  logic                      nice_rst_n,
  // Operation start from the controller
  input  logic                      start,
  input  nice_pkg::nice_op_e        op,
  input  logic [nice_pkg::XLEN-1:0] base_addr,
  // Memory command
  output logic                      icb_cmd_valid,
  input  logic                      icb_cmd_ready,
  output nice_pkg::icb_cmd_t        icb_cmd,
  // Memory response
  input  logic                      icb_rsp_valid,
  output logic                      icb_rsp_ready,
  input  nice_pkg::icb_rsp_t        icb_rsp,
  // Row buffer read port for stores
  output logic [IDX_W-1:0]          wr_idx,
  input  logic [nice_pkg::XLEN-1:0] wr_data,
  // Beat reports
  output logic                      beat_valid,
  output logic [IDX_W-1:0]          beat_idx,
  output logic [nice_pkg::XLEN-1:0] beat_data,
  output logic                      beat_err,
  output logic                      last_beat
);
  import nice_pkg::*;

  // Counters have to reach ROW_LEN itself
  localparam int CNT_W = $clog2(ROW_LEN + 1);

  logic             busy;
  logic [CNT_W-1:0] cmd_cnt;
  logic [CNT_W-1:0] rsp_cnt;
  logic [XLEN-1:0]  addr_q;
  logic             cmd_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Command side
  ////////////////////////////////////////////////////////////////////////////

  // May run ahead of responses, the bus keeps order
  assign icb_cmd_valid = busy && (cmd_cnt < CNT_W'(ROW_LEN));
  assign cmd_fire      = icb_cmd_valid && icb_cmd_ready;

  assign icb_cmd.addr  = addr_q;
  assign icb_cmd.read  = (op != OP_SBUF);
  assign icb_cmd.wdata = wr_data;

  // Store data follows the command being offered
  assign wr_idx = cmd_cnt[IDX_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////
  assign icb_rsp_ready = 1'b1;
  assign beat_valid    = icb_rsp_valid && icb_rsp_ready;
  assign beat_idx      = rsp_cnt[IDX_W-1:0];
  assign beat_data     = icb_rsp.rdata;
  assign beat_err      = icb_rsp.err;
  assign last_beat     = beat_valid && (rsp_cnt == CNT_W'(ROW_LEN - 1));

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      busy    <= 1'b0;
      cmd_cnt <= '0;
      rsp_cnt <= '0;
    end
    else
    begin
      // Busy from the cycle after start until the final beat
      if (start)
        busy <= 1'b1;
      else if (last_beat)
        busy <= 1'b0;
      if (start)
        cmd_cnt <= '0;
      else if (cmd_fire)
        cmd_cnt <= cmd_cnt + 1'b1;
      if (start)
        rsp_cnt <= '0;
      else if (beat_valid)
        rsp_cnt <= rsp_cnt + 1'b1;
    end
  end

  // Word address, stepped on each accepted command
  always_ff @(posedge nice_clk)
  begin
    if (start)
      addr_q <= base_addr;
    else if (cmd_fire)
      addr_q <= addr_q + WORD_BYTES;
  end

  // A response must belong to a command already sent
  a_rsp_after_cmd : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    beat_valid |-> (rsp_cnt < cmd_cnt))
    else $error("memory response without an outstanding command");

endmodule

//--- design/nice_row_buf.sv
////////////////////////////////////////////////////////////////////////////
// Row buffer of ROW_LEN words. Loads or accumulates memory beats, feeds
// store data to the LSU and keeps the running row sum
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module nice_row_buf #(
  parameter  int ROW_LEN = 3,
  localparam int IDX_W   = (ROW_LEN > 1) ? $clog2(ROW_LEN) : 1
) (
  input  logic                      nice_clk,
  input  logic                      nice_rst_n,
  input  logic                      start,
  input  nice_pkg::nice_op_e        op,
  // Beats from the LSU
  input  logic                      beat_valid,
  input  logic [IDX_W-1:0]          beat_idx,
  input  logic [nice_pkg::XLEN-1:0] beat_data,
  // Store read port
  input  logic [IDX_W-1:0]          wr_idx,
  output logic [nice_pkg::XLEN-1:0] wr_data,
  output logic [nice_pkg::XLEN-1:0] row_sum
);
  import nice_pkg::*;

  logic [XLEN-1:0] rows [ROW_LEN];
  logic            beat_in_row;
  logic            wr_in_row;

  // Index range only matters when ROW_LEN is not a power of two
  assign beat_in_row = (32'(beat_idx) < ROW_LEN);
  assign wr_in_row   = (32'(wr_idx) < ROW_LEN);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      for (int i = 0; i < ROW_LEN; i++)
        rows[i] <= '0;
    end
    else if (beat_valid && beat_in_row)
    begin
      case (op)
        // lbuf overwrites
        OP_LBUF:   rows[beat_idx] <= beat_data;
        // rowsum adds straight from the beat, wraps on overflow
        OP_ROWSUM: rows[beat_idx] <= rows[beat_idx] + beat_data;
        default:   ;
      endcase
    end
  end

  // Row sum of the current rowsum, cleared at every start
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      row_sum <= '0;
    else if (start)
      row_sum <= '0;
    else if (beat_valid && (op == OP_ROWSUM))
      row_sum <= row_sum + beat_data;
  end

  // Read-out for sbuf, zero past the row end
  assign wr_data = wr_in_row ? rows[wr_idx] : '0;

endmodule

//--- design/nice_core.sv
////////////////////////////////////////////////////////////////////////////
// NICE coprocessor top level. Connects controller, LSU and row buffer to
// the request, response and memory channels; ROW_LEN sets the row length
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module nice_core #(
  parameter  int ROW_LEN = 3,
  localparam int IDX_W   = (ROW_LEN > 1) ? $clog2(ROW_LEN) : 1
) (
  input  logic                 nice_clk,
  input  logic                 nice_rst_n,
  output logic                 active,
  output logic                 mem_holdup,
  // Request
  input  logic                 req_valid,
  output logic                 req_ready,
  input  nice_pkg::nice_req_t  req,
  // Response
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output nice_pkg::nice_rsp_t  rsp,
  // Memory command
  output logic                 icb_cmd_valid,
  input  logic                 icb_cmd_ready,
  output nice_pkg::icb_cmd_t   icb_cmd,
  // Memory response
  input  logic                 icb_rsp_valid,
  output logic                 icb_rsp_ready,
  input  nice_pkg::icb_rsp_t   icb_rsp
);
  import nice_pkg::*;

  // Start and op
  logic             start;
  nice_op_e         op;
  logic [XLEN-1:0]  base_addr;
  // Beats
  logic             beat_valid;
  logic [IDX_W-1:0] beat_idx;
  logic [XLEN-1:0]  beat_data;
  logic             beat_err;
  logic             last_beat;
  // Store data and result
  logic [IDX_W-1:0] wr_idx;
  logic [XLEN-1:0]  wr_data;
  logic [XLEN-1:0]  row_sum;

  nice_ctrl #(
    .ROW_LEN (ROW_LEN)
  ) i_ctrl (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .start      (start),
    .op         (op),
    .base_addr  (base_addr),
    .beat_valid (beat_valid),
    .beat_err   (beat_err),
    .last_beat  (last_beat),
    .row_sum    (row_sum),
    .active     (active),
    .mem_holdup (mem_holdup)
  );

  nice_lsu #(
    .ROW_LEN (ROW_LEN)
  ) i_lsu (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .start         (start),
    .op            (op),
    .base_addr     (base_addr),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp       (icb_rsp),
    .wr_idx        (wr_idx),
    .wr_data       (wr_data),
    .beat_valid    (beat_valid),
    .beat_idx      (beat_idx),
    .beat_data     (beat_data),
    .beat_err      (beat_err),
    .last_beat     (last_beat)
  );

  nice_row_buf #(
    .ROW_LEN (ROW_LEN)
  ) i_row_buf (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .start      (start),
    .op         (op),
    .beat_valid (beat_valid),
    .beat_idx   (beat_idx),
    .beat_data  (beat_data),
    .wr_idx     (wr_idx),
    .wr_data    (wr_data),
    .row_sum    (row_sum)
  );

endmodule

//--- tb/nice_mem_model.sv
////////////////////////////////////////////////////////////////////////////
// Word memory on the ICB-style bus for the NICE testbench. Random command
// stall, in-order responses one cycle later, error region at ERR_BASE
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module nice_mem_model #(
  parameter int                        DEPTH    = 256,
  parameter logic [nice_pkg::XLEN-1:0] ERR_BASE = 32'h0000_0380
) (
  input  logic                      nice_clk,
  input  logic                      nice_rst_n,
  // Command channel
  input  logic                      icb_cmd_valid,
  output logic                      icb_cmd_ready,
  input  nice_pkg::icb_cmd_t        icb_cmd,
  // Response channel
  output logic                      icb_rsp_valid,
  input  logic                      icb_rsp_ready,
  output nice_pkg::icb_rsp_t        icb_rsp,
  // Record of the last write, one cycle after the command transfer
  output logic                      wr_seen,
  output logic [nice_pkg::XLEN-1:0] wr_addr,
  output logic [nice_pkg::XLEN-1:0] wr_data
);
  import nice_pkg::*;

  localparam int AW = $clog2(DEPTH);

  // Preloaded by the testbench at time zero
  logic [XLEN-1:0] mem [DEPTH];
  logic            stall;
  logic            cmd_fire;
  logic [AW-1:0]   idx;
  logic            in_err;

  // A pending response blocks the next command
  assign icb_cmd_ready = !stall && (!icb_rsp_valid || icb_rsp_ready);
  assign cmd_fire      = icb_cmd_valid && icb_cmd_ready;
  assign idx           = icb_cmd.addr[AW+1:2];
  assign in_err        = (icb_cmd.addr >= ERR_BASE);

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      stall         <= 1'b0;
      icb_rsp_valid <= 1'b0;
      icb_rsp       <= '0;
      wr_seen       <= 1'b0;
      wr_addr       <= '0;
      wr_data       <= '0;
    end
    else
    begin
      // About one cycle in four stalls
      stall   <= ($urandom_range(3, 0) == 0);
      wr_seen <= 1'b0;
      if (icb_rsp_valid && icb_rsp_ready)
        icb_rsp_valid <= 1'b0;
      if (cmd_fire)
      begin
        icb_rsp_valid <= 1'b1;
        // Read data comes back even from the error region, writes return zero
        icb_rsp.rdata <= icb_cmd.read ? mem[idx] : '0;
        icb_rsp.err   <= in_err;
        if (!icb_cmd.read)
        begin
          wr_seen <= 1'b1;
          wr_addr <= icb_cmd.addr;
          wr_data <= icb_cmd.wdata;
        end
      end
    end
  end

  // Writes into the error region are dropped
  always @(posedge nice_clk)
  begin
    if (cmd_fire && !icb_cmd.read && !in_err)
      mem[idx] = icb_cmd.wdata;
  end

endmodule

//--- tb/tb_nice_core.sv
////////////////////////////////////////////////////////////////////////////
// Testbench of the NICE coprocessor. Runs lbuf, sbuf, rowsum and bad ops
// against a stalling memory; concurrent assertions check every response
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_nice_core;
  import nice_pkg::*;

  localparam int              ROW_LEN  = 3;
  localparam logic [31:0]     SEED     = 32'h5df46e73;
  localparam logic [XLEN-1:0] ERR_BASE = 32'h0000_0380;
  // Per op, stall and back-pressure included, for up to 30 ops
  localparam int OP_BUDGET      = 133;
  localparam int TIMEOUT_CYCLES = 30 * OP_BUDGET + 10;

  logic            nice_clk;
  logic            nice_rst_n;
  logic            active;
  logic            mem_holdup;
  logic            req_valid;
  logic            req_ready;
  nice_req_t       req;
  logic            rsp_valid;
  logic            rsp_ready;
  nice_rsp_t       rsp;
  logic            icb_cmd_valid;
  logic            icb_cmd_ready;
  icb_cmd_t        icb_cmd;
  logic            icb_rsp_valid;
  logic            icb_rsp_ready;
  icb_rsp_t        icb_rsp;
  logic            wr_seen;
  logic [XLEN-1:0] wr_addr;
  logic [XLEN-1:0] wr_data;

  ////////////////////////////////////////////////////////////////////////////
  // Reference state, set at the negedge before each request
  ////////////////////////////////////////////////////////////////////////////
  logic [XLEN-1:0] ref_mem [256];
  logic [XLEN-1:0] exp_row [ROW_LEN];
  nice_rsp_t       exp_rsp;
  logic [XLEN-1:0] wr_base;
  logic            exp_store;
  logic            exp_mem_op;
  string           test_name;

  // Per-op bookkeeping, restarted on every request transfer
  int              cycle_cnt = 0;
  int              wr_cnt;
  int              rsp_seen;
  logic            post_rst_q;
  logic            mem_pending;
  logic            bad_pending;
  logic [XLEN-1:0] exp_wr_addr;
  logic [XLEN-1:0] exp_wr_data;

  nice_core #(
    .ROW_LEN (ROW_LEN)
  ) i_dut (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .active        (active),
    .mem_holdup    (mem_holdup),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp       (icb_rsp)
  );

  nice_mem_model #(
    .DEPTH    (256),
    .ERR_BASE (ERR_BASE)
  ) i_mem (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp       (icb_rsp),
    .wr_seen       (wr_seen),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data)
  );

  initial
  begin
    nice_clk = 1'b0;
    forever #10 nice_clk = ~nice_clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    stop_run($sformatf("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                       test_name, what, expected, actual));
  endtask

  // Cycle limit
  always @(posedge nice_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_run($sformatf("Timeout after %0d cycles in %s", cycle_cnt, test_name));
  end

  // Stores go to consecutive words from the sbuf base
  assign exp_wr_addr = wr_base + 32'd4 * 32'(wr_cnt);
  assign exp_wr_data = (wr_cnt < ROW_LEN) ? exp_row[wr_cnt] : '0;

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      post_rst_q  <= 1'b0;
      wr_cnt      <= 0;
      rsp_seen    <= 0;
      mem_pending <= 1'b0;
      bad_pending <= 1'b0;
    end
    else
    begin
      post_rst_q <= 1'b1;
      if (req_valid && req_ready)
      begin
        wr_cnt      <= 0;
        rsp_seen    <= 0;
        mem_pending <= exp_mem_op;
        bad_pending <= !exp_mem_op;
      end
      else
      begin
        if (wr_seen)
          wr_cnt <= wr_cnt + 1;
        if (icb_rsp_valid && icb_rsp_ready)
          rsp_seen <= rsp_seen + 1;
        if (rsp_valid)
          mem_pending <= 1'b0;
        if (rsp_valid && rsp_ready)
          bad_pending <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  a_reset_state : assert property (@(posedge nice_clk)
    (!nice_rst_n || !post_rst_q) |->
      (!rsp_valid && !icb_cmd_valid && !mem_holdup && req_ready))
    else stop_run("Core outputs not idle during or right after reset");

  a_rsp_value : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    rsp_valid |-> (rsp == exp_rsp))
    else report_mismatch("response", 64'(exp_rsp), 64'($sampled(rsp)));

  a_wr_expected : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    wr_seen |-> (exp_store && (wr_cnt < ROW_LEN)))
    else stop_run("Memory write outside an sbuf or past the row end");

  a_wr_addr : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    wr_seen |-> (wr_addr == exp_wr_addr))
    else report_mismatch("write address", 64'($sampled(exp_wr_addr)),
                         64'($sampled(wr_addr)));

  a_wr_data : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    wr_seen |-> (wr_data == exp_wr_data))
    else report_mismatch("write data", 64'($sampled(exp_wr_data)),
                         64'($sampled(wr_data)));

  a_wr_count : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (rsp_valid && exp_store) |-> (wr_cnt == ROW_LEN))
    else stop_run("sbuf answered before the whole row was written");

  // Memory responses are never held off by the core
  a_icb_rsp_ready : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    icb_rsp_ready)
    else stop_run("Core not ready for a memory response");

  // Busy outside idle, and idle is exactly where req_ready is high
  a_active : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    active == (req_valid || !req_ready))
    else report_mismatch("active", 64'($sampled(req_valid) || !$sampled(req_ready)),
                         64'($sampled(active)));

  // Back-pressure
  a_rsp_stable : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else stop_run("Response dropped or changed while rsp_ready was low");

  a_busy_no_req : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    rsp_valid |-> !req_ready)
    else stop_run("Request accepted while a response was pending");

  a_holdup : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (mem_pending && !rsp_valid) |-> mem_holdup)
    else stop_run("mem_holdup low during a memory operation");

  // Response exactly one cycle after the last memory beat
  a_rsp_timing : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (icb_rsp_valid && icb_rsp_ready && (rsp_seen == ROW_LEN - 1)) |=> $rose(rsp_valid))
    else stop_run("Response did not follow the last memory beat by one cycle");

  a_bad_no_cmd : assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    bad_pending |-> !icb_cmd_valid)
    else stop_run("Memory command issued for an unsupported instruction");

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [XLEN-1:0] encode_inst(input nice_op_e kind);
    logic [6:0] f7;
    logic [2:0] f3;
    case (kind)
      OP_LBUF:
      begin
        f7 = FUNCT7_LBUF;
        f3 = FUNCT3_MEM;
      end
      OP_SBUF:
      begin
        f7 = FUNCT7_SBUF;
        f3 = FUNCT3_MEM;
      end
      OP_ROWSUM:
      begin
        f7 = FUNCT7_ROWSUM;
        f3 = FUNCT3_SUM;
      end
      // Custom3 with a funct7 nobody decodes
      default:
      begin
        f7 = 7'h7f;
        f3 = FUNCT3_MEM;
      end
    endcase
    return {f7, 5'd0, 5'd10, f3, 5'd11, OPC_CUSTOM3};
  endfunction

  // rsp_ready is high about one cycle in three
  function automatic logic pick_ready();
    return ($urandom_range(2, 0) == 0);
  endfunction

  task automatic run_op(input string name, input nice_op_e kind, input logic [XLEN-1:0] addr);
    int              base;
    logic [XLEN-1:0] sum;
    logic            err;
    logic            done;
    @(negedge nice_clk);
    base = int'(addr[9:2]);
    sum  = '0;
    err  = (kind == OP_NONE);
    for (int i = 0; i < ROW_LEN; i++)
    begin
      if (kind != OP_NONE && (addr + 32'(4 * i)) >= ERR_BASE)
        err = 1'b1;
      case (kind)
        OP_LBUF:
          exp_row[i] = ref_mem[base + i];
        OP_ROWSUM:
        begin
          sum        = sum + ref_mem[base + i];
          exp_row[i] = exp_row[i] + ref_mem[base + i];
        end
        OP_SBUF:
          ref_mem[base + i] = exp_row[i];
        default: ;
      endcase
    end
    test_name    = name;
    wr_base      = addr;
    exp_store    = (kind == OP_SBUF);
    exp_mem_op   = (kind != OP_NONE);
    exp_rsp.rdat = (kind == OP_ROWSUM) ? sum : '0;
    exp_rsp.err  = err;
    // Request, held until the core takes it
    @(posedge nice_clk);
    req_valid <= 1'b1;
    req.inst  <= encode_inst(kind);
    req.rs1   <= addr;
    do @(negedge nice_clk); while (!req_ready);
    @(posedge nice_clk);
    req_valid <= 1'b0;
    rsp_ready <= pick_ready();
    do
    begin
      @(negedge nice_clk);
      done = rsp_valid && rsp_ready;
      @(posedge nice_clk);
      rsp_ready <= done ? 1'b0 : pick_ready();
    end
    while (!done);
  endtask

  initial
  begin
    int              pick;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] word;
    void'($urandom(SEED));
    nice_rst_n = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    rsp_ready  = 1'b0;
    test_name  = "reset";
    exp_rsp    = '0;
    exp_store  = 1'b0;
    exp_mem_op = 1'b0;
    wr_base    = '0;
    for (int i = 0; i < ROW_LEN; i++)
      exp_row[i] = '0;
    // Same random words in the model and in the reference copy
    for (int i = 0; i < 256; i++)
    begin
      word        = $urandom;
      ref_mem[i]  = word;
      i_mem.mem[i] = word;
    end
    repeat (8) @(posedge nice_clk);
    nice_rst_n <= 1'b1;
    repeat (2) @(posedge nice_clk);

    run_op("lbuf_a", OP_LBUF, 32'h0000_0040);
    run_op("sbuf_b", OP_SBUF, 32'h0000_0100);
    run_op("rowsum_c", OP_ROWSUM, 32'h0000_0200);
    run_op("sbuf_sum", OP_SBUF, 32'h0000_0140);
    run_op("lbuf_reload", OP_LBUF, 32'h0000_0100);
    run_op("lbuf_err", OP_LBUF, ERR_BASE - 32'd4);
    run_op("bad_funct7", OP_NONE, 32'h0000_0080);
    run_op("rowsum_after_bad", OP_ROWSUM, 32'h0000_0010);

    // Mixed ops on random word addresses below the error region
    repeat (12)
    begin
      pick = $urandom_range(2, 0);
      addr = 32'($urandom_range(188, 0)) * 32'd4;
      run_op("random_mix", nice_op_e'(2'(pick + 1)), addr);
    end

    repeat (4) @(posedge nice_clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- tb.f
design/nice_pkg.sv
design/nice_ctrl.sv
design/nice_lsu.sv
design/nice_row_buf.sv
design/nice_core.sv
tb/nice_mem_model.sv
tb/tb_nice_core.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = tb_nice_core
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build and run; the pass line in the log decides the status
sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
